//--- verilog/chdr_tg_pkg.sv
`default_nettype none

package chdr_tg_pkg;

  localparam int DATA_W         = 64;  // Stream data width
  localparam int MTU_LOG2       = 5;   // log2 of max lines per packet
  localparam int NUM_NODES_LOG2 = 4;   // log2 of generators in the fabric
  localparam int NUM_NODES      = 1 << NUM_NODES_LOG2;

  // Traffic pattern codes, ASCII letters
  localparam logic [7:0] PATT_LOOPBACK       = 8'h4c;  // L
  localparam logic [7:0] PATT_NEIGHBOR       = 8'h4e;  // N
  localparam logic [7:0] PATT_BIT_COMPLEMENT = 8'h43;  // C
  localparam logic [7:0] PATT_SEQUENTIAL     = 8'h53;  // S
  localparam logic [7:0] PATT_UNIFORM        = 8'h55;  // U
  localparam logic [7:0] PATT_UNIFORM_OTHERS = 8'h4f;  // O

  // CHDR header bit that announces a timestamp line
  localparam int HAS_TIME_BIT = 61;

  // Base seeds for the random sources, mixed with the node ID
  localparam logic [31:0] GEN_SEED_BASE = 32'h9e37_79b9;
  localparam logic [31:0] THR_SEED_BASE = 32'h7f4a_7c15;

  // CHDR data header
  // 63:62 type (data), 61 has_time, 60 eob, 59:48 seqnum,
  // 47:32 length in bytes, 31:16 src, 15:0 dst
  function automatic logic [63:0] pack_chdr_hdr(
    input logic        has_time,
    input logic [11:0] seqnum,
    input logic [15:0] length,
    input logic [15:0] src_sid,
    input logic [15:0] dst_sid
  );
    logic [63:0] hdr;
    hdr                = '0;        // Data packet, no EOB
    hdr[HAS_TIME_BIT]  = has_time;
    hdr[59:48]         = seqnum;
    hdr[47:32]         = length;
    hdr[31:16]         = src_sid;
    hdr[15:0]          = dst_sid;
    return hdr;
  endfunction

endpackage

`default_nettype wire

//--- verilog/tg_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module tg_lfsr #(
  parameter logic [31:0] SEED = 32'h0000_0001  // Must be nonzero
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         i_advance,  // Step to the next value
  output logic [31:0] o_value
);

  logic [31:0] state;
  logic [31:0] x1, x2, x3;

  // Marsaglia xorshift32, shifts 13/17/5
  assign x1 = state ^ (state << 13);
  assign x2 = x1 ^ (x1 >> 17);
  assign x3 = x2 ^ (x2 << 5);

  always_ff @(posedge clk) begin
    if (rst) state <= SEED;
    else if (i_advance) state <= x3;
  end

  assign o_value = state;

endmodule

`default_nettype wire

//--- verilog/chdr_pkt_gen.sv
`timescale 1ns/1ns
`default_nettype none

module chdr_pkt_gen
  import chdr_tg_pkg::*;
#(
  parameter int          NODE_ID = 0,
  parameter logic [31:0] SEED    = 32'h1
) (
  input  wire                clk,
  input  wire                rst,
  input  wire  [63:0]        i_current_time,
  input  wire                i_start_stb,
  input  wire  [15:0]        i_lines_per_pkt,     // Header + timestamp + ramp
  input  wire  [7:0]         i_traffic_patt,
  input  wire  [31:0]        i_num_pkts_to_send,
  output logic [DATA_W-1:0]  o_tdata,
  output logic               o_tlast,
  output logic               o_tvalid,
  input  wire                i_tready,
  output logic               o_session_active,
  output logic [63:0]        o_session_duration,
  output logic [31:0]        o_xfer_count,
  output logic [31:0]        o_pkt_count
);

  localparam logic [NUM_NODES_LOG2-1:0] NODE_LO = NUM_NODES_LOG2'(NODE_ID);

  logic                      running;
  logic [15:0]               line_idx;    // Line within current packet
  logic [31:0]               pkt_idx;     // Packets completed this session
  logic [31:0]               xfer_cnt;
  logic [63:0]               start_time, stop_time;
  logic [15:0]               lines_q;     // Session settings latched at start
  logic [7:0]                patt_q;
  logic [31:0]               num_pkts_q;
  logic [NUM_NODES_LOG2-1:0] cur_dst;     // Also serves as last destination
  logic [31:0]               rnd;
  logic                      start, accept, last_pkt, pick;

  // Next destination from pattern, previous destination and a random draw
  function automatic logic [NUM_NODES_LOG2-1:0] choose_dst(
    input logic [7:0]                patt,
    input logic [NUM_NODES_LOG2-1:0] last,
    input logic [NUM_NODES_LOG2-1:0] draw
  );
    case (patt)
      PATT_LOOPBACK:       return NODE_LO;
      PATT_NEIGHBOR:       return NODE_LO + 1'b1;
      PATT_BIT_COMPLEMENT: return ~NODE_LO;        // NUM_NODES-1-NODE_ID
      PATT_SEQUENTIAL:     return last + 1'b1;     // Wraps mod NUM_NODES
      PATT_UNIFORM:        return draw;
      PATT_UNIFORM_OTHERS: return (draw == NODE_LO) ? NODE_LO + 1'b1 : draw;
      default:             return '0;
    endcase
  endfunction

  assign start    = i_start_stb && !running && (i_num_pkts_to_send != 32'd0);
  assign accept   = o_tvalid && i_tready;
  assign last_pkt = (pkt_idx == num_pkts_q - 32'd1);
  assign pick     = start || (accept && o_tlast && !last_pkt);  // One draw per header

  tg_lfsr #(.SEED(SEED)) lfsr_inst (
    .clk       (clk),
    .rst       (rst),
    .i_advance (pick),
    .o_value   (rnd)
  );

  // Session control and metrics
  always_ff @(posedge clk) begin
    if (rst) begin
      running    <= 1'b0;
      line_idx   <= '0;
      pkt_idx    <= '0;
      xfer_cnt   <= '0;
      start_time <= '0;
      stop_time  <= '0;
    end else if (start) begin
      running    <= 1'b1;
      line_idx   <= '0;
      pkt_idx    <= '0;
      xfer_cnt   <= '0;
      start_time <= i_current_time;
      stop_time  <= i_current_time;  // Duration reads zero while running
    end else if (accept) begin
      xfer_cnt <= xfer_cnt + 32'd1;
      if (o_tlast) begin
        line_idx <= '0;
        pkt_idx  <= pkt_idx + 32'd1;
        if (last_pkt) begin
          running   <= 1'b0;
          stop_time <= i_current_time;
        end
      end else begin
        line_idx <= line_idx + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      lines_q    <= i_lines_per_pkt;
      patt_q     <= i_traffic_patt;
      num_pkts_q <= i_num_pkts_to_send;
    end
    // Sequential restarts from NODE_ID-1 so the first packet goes to NODE_ID
    if (pick)
      cur_dst <= choose_dst(start ? i_traffic_patt : patt_q,
                            start ? NODE_LO - 1'b1 : cur_dst,
                            rnd[31 -: NUM_NODES_LOG2]);
  end

  // Beat mux
  always_comb begin
    if (line_idx == 16'd0)
      o_tdata = pack_chdr_hdr(1'b1, pkt_idx[11:0], {lines_q[12:0], 3'b000},
                              16'(NODE_ID), 16'(cur_dst));
    else if (line_idx == 16'd1)
      o_tdata = '0;                             // Timestamp filled in downstream
    else
      o_tdata = DATA_W'(line_idx - 16'd2);      // Ramp from 0
  end

  assign o_tvalid           = running;
  assign o_tlast            = (line_idx == lines_q - 16'd1);
  assign o_session_active   = running;
  assign o_session_duration = stop_time - start_time;
  assign o_xfer_count       = xfer_cnt;
  assign o_pkt_count        = pkt_idx;

  a_min_lines: assert property (@(posedge clk) disable iff (rst)
    start |-> i_lines_per_pkt >= 16'd3)
    else $error("Session started with fewer than 3 lines per packet");

endmodule

`default_nettype wire

//--- verilog/axis_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module axis_fifo
  import chdr_tg_pkg::*;
#(
  parameter int DEPTH_LOG2 = 4
) (
  input  wire               clk,
  input  wire               rst,
  input  wire  [DATA_W-1:0] i_tdata,
  input  wire               i_tlast,
  input  wire               i_tvalid,
  output logic              o_tready,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  wire               i_tready
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DATA_W:0]       mem [DEPTH];  // {last, data}
  logic [DEPTH_LOG2-1:0] wr_ptr, rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  wr, rd;

  assign wr = i_tvalid && o_tready;
  assign rd = o_tvalid && i_tready;

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= {i_tlast, i_tdata};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap naturally
      if (rd) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (DEPTH_LOG2 + 1)'(wr) - (DEPTH_LOG2 + 1)'(rd);
    end
  end

  assign o_tready            = (count != (DEPTH_LOG2 + 1)'(DEPTH));
  assign o_tvalid            = (count != '0);
  assign {o_tlast, o_tdata}  = mem[rd_ptr];

  // Full with no read must stay full, so nothing was overwritten
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    count == (DEPTH_LOG2 + 1)'(DEPTH) && !rd |=> count == (DEPTH_LOG2 + 1)'(DEPTH))
    else $error("FIFO written while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    count == '0 && !wr |=> count == '0)
    else $error("FIFO read while empty");

endmodule

`default_nettype wire

//--- verilog/ts_insert_throttle.sv
`timescale 1ns/1ns
`default_nettype none

module ts_insert_throttle
  import chdr_tg_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h1
) (
  input  wire               clk,
  input  wire               rst,
  input  wire  [63:0]       i_current_time,
  input  wire  [7:0]        i_injection_rate,  // Percent, 100 never throttles
  input  wire  [DATA_W-1:0] i_tdata,
  input  wire               i_tlast,
  input  wire               i_tvalid,
  output logic              o_tready,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  wire               i_tready
);

  typedef enum logic [1:0] {ST_HDR, ST_TS, ST_BODY} state_t;

  state_t      state;
  logic        throttle;
  logic [31:0] rnd;
  logic [22:0] scaled;
  logic [7:0]  draw;     // 0..99

  tg_lfsr #(.SEED(SEED)) lfsr_inst (
    .clk       (clk),
    .rst       (rst),
    .i_advance (1'b1),  // New draw every cycle
    .o_value   (rnd)
  );

  assign scaled = 23'(rnd[15:0]) * 23'd100;
  assign draw   = {1'b0, scaled[22:16]};

  always_ff @(posedge clk) begin
    if (rst) throttle <= 1'b1;
    else throttle <= (draw >= i_injection_rate);
  end

  // Packet position tracker, moves on accepted beats
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else if (o_tvalid && i_tready) begin
      case (state)
        ST_HDR:  if (!i_tlast) state <= i_tdata[HAS_TIME_BIT] ? ST_TS : ST_BODY;
        ST_TS:   state <= i_tlast ? ST_HDR : ST_BODY;
        ST_BODY: state <= i_tlast ? ST_HDR : ST_BODY;
        default: state <= ST_HDR;
      endcase
    end
  end

  assign o_tdata  = (state == ST_TS) ? i_current_time : i_tdata;  // Stamp at release
  assign o_tlast  = i_tlast;
  assign o_tvalid = i_tvalid && !throttle;
  assign o_tready = i_tready && !throttle;

endmodule

`default_nettype wire

//--- verilog/axis_pkt_gate.sv
`timescale 1ns/1ns
`default_nettype none

module axis_pkt_gate
  import chdr_tg_pkg::*;
#(
  parameter int DEPTH_LOG2 = 7
) (
  input  wire               clk,
  input  wire               rst,
  input  wire  [DATA_W-1:0] i_tdata,
  input  wire               i_tlast,
  input  wire               i_tvalid,
  output logic              o_tready,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  wire               i_tready
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DATA_W:0]       mem [DEPTH];  // {last, data}
  logic [DEPTH_LOG2-1:0] wr_ptr, rd_ptr;
  logic [DEPTH_LOG2:0]   count;        // Lines held
  logic [DEPTH_LOG2:0]   pkt_cnt;      // Complete packets held
  logic                  wr, rd;
  logic                  pkt_in, pkt_out;

  assign wr      = i_tvalid && o_tready;
  assign rd      = o_tvalid && i_tready;
  assign pkt_in  = wr && i_tlast;
  assign pkt_out = rd && o_tlast;

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= {i_tlast, i_tdata};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      pkt_cnt <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + 1'b1;
      if (rd) rd_ptr <= rd_ptr + 1'b1;
      count   <= count + (DEPTH_LOG2 + 1)'(wr) - (DEPTH_LOG2 + 1)'(rd);
      // A packet counts only once its last line is stored
      pkt_cnt <= pkt_cnt + (DEPTH_LOG2 + 1)'(pkt_in) - (DEPTH_LOG2 + 1)'(pkt_out);
    end
  end

  assign o_tready           = (count != (DEPTH_LOG2 + 1)'(DEPTH));
  assign o_tvalid           = (pkt_cnt != '0);  // Whole packet ready to stream
  assign {o_tlast, o_tdata} = mem[rd_ptr];

  // Once a packet is offered it drains without gaps from the gate side
  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    o_tvalid && !i_tready |=> o_tvalid)
    else $error("Gate dropped valid without a transfer");

endmodule

`default_nettype wire

//--- verilog/chdr_traffic_source.sv
`timescale 1ns/1ns
`default_nettype none

module chdr_traffic_source
  import chdr_tg_pkg::*;
#(
  parameter int NODE_ID = 0
) (
  input  wire               clk,
  input  wire               rst,
  input  wire  [63:0]       i_current_time,
  input  wire               i_start_stb,
  input  wire  [7:0]        i_injection_rate,
  input  wire  [15:0]       i_lines_per_pkt,
  input  wire  [7:0]        i_traffic_patt,
  input  wire  [31:0]       i_num_pkts_to_send,
  output logic [DATA_W-1:0] o_m_tdata,
  output logic              o_m_tlast,
  output logic              o_m_tvalid,
  input  wire               i_m_tready,
  output logic              o_session_active,
  output logic [63:0]       o_session_duration,
  output logic [31:0]       o_xfer_count,
  output logic [31:0]       o_pkt_count
);

  logic [DATA_W-1:0] gen_tdata, fifo_tdata, gate_in_tdata;
  logic              gen_tlast, fifo_tlast, gate_in_tlast;
  logic              gen_tvalid, fifo_tvalid, gate_in_tvalid;
  logic              gen_tready, fifo_tready, gate_in_tready;

  // Seeds differ per node and per random source
  chdr_pkt_gen #(
    .NODE_ID (NODE_ID),
    .SEED    (GEN_SEED_BASE ^ 32'(NODE_ID))
  ) gen_inst (
    .clk (clk), .rst (rst),
    .i_current_time (i_current_time), .i_start_stb (i_start_stb),
    .i_lines_per_pkt (i_lines_per_pkt), .i_traffic_patt (i_traffic_patt),
    .i_num_pkts_to_send (i_num_pkts_to_send),
    .o_tdata (gen_tdata), .o_tlast (gen_tlast),
    .o_tvalid (gen_tvalid), .i_tready (gen_tready),
    .o_session_active (o_session_active), .o_session_duration (o_session_duration),
    .o_xfer_count (o_xfer_count), .o_pkt_count (o_pkt_count)
  );

  axis_fifo #(.DEPTH_LOG2(MTU_LOG2 + 1)) fifo_inst (  // Short back-pressure buffer
    .clk (clk), .rst (rst),
    .i_tdata (gen_tdata), .i_tlast (gen_tlast),
    .i_tvalid (gen_tvalid), .o_tready (gen_tready),
    .o_tdata (fifo_tdata), .o_tlast (fifo_tlast),
    .o_tvalid (fifo_tvalid), .i_tready (fifo_tready)
  );

  ts_insert_throttle #(.SEED(THR_SEED_BASE ^ (32'(NODE_ID) << 8))) throttle_inst (
    .clk (clk), .rst (rst),
    .i_current_time (i_current_time), .i_injection_rate (i_injection_rate),
    .i_tdata (fifo_tdata), .i_tlast (fifo_tlast),
    .i_tvalid (fifo_tvalid), .o_tready (fifo_tready),
    .o_tdata (gate_in_tdata), .o_tlast (gate_in_tlast),
    .o_tvalid (gate_in_tvalid), .i_tready (gate_in_tready)
  );

  axis_pkt_gate #(.DEPTH_LOG2(MTU_LOG2 + 2)) gate_inst (  // Smooths throttle gaps
    .clk (clk), .rst (rst),
    .i_tdata (gate_in_tdata), .i_tlast (gate_in_tlast),
    .i_tvalid (gate_in_tvalid), .o_tready (gate_in_tready),
    .o_tdata (o_m_tdata), .o_tlast (o_m_tlast),
    .o_tvalid (o_m_tvalid), .i_tready (i_m_tready)
  );

endmodule

`default_nettype wire

//--- dv/chdr_traffic_source_tb.sv
`timescale 1ns/1ns
`default_nettype none

module chdr_traffic_source_tb
  import chdr_tg_pkg::*;
();

  localparam int NODE_ID   = 5;
  localparam int MAX_LINES = 1300;                   // Upper bound over all sessions
  localparam int WATCHDOG  = MAX_LINES * 4 + 2000;   // Margin covers stall window and resets

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [63:0] cur_time = '0;
  logic        start_stb = 1'b0;
  logic [7:0]  injection_rate = 8'd100;
  logic [15:0] lines_per_pkt = 16'd6;
  logic [7:0]  traffic_patt = PATT_LOOPBACK;
  logic [31:0] num_pkts = '0;
  logic        m_tready = 1'b1;

  logic [DATA_W-1:0] m_tdata;
  logic              m_tlast, m_tvalid, session_active;
  logic [63:0]       session_duration;
  logic [31:0]       xfer_count, pkt_count;

  // Test bookkeeping shared by the tasks and the monitor
  string       cur_name = "idle";
  logic [7:0]  cfg_patt = PATT_LOOPBACK;
  int          cfg_lines = 6, cfg_pkts = 0, cfg_total = 0;
  int          exp_pkt = 0, exp_line = 0, beats_seen = 0;
  int          errors = 0, err_mark = 0, tests_run = 0, tests_passed = 0;
  logic [63:0] sess_start = '0, last_ts = '0;
  logic [63:0] mon_ts;
  logic [15:0] mon_dst;
  logic [31:0] rng = 32'hf4ab;
  logic        ready_random = 1'b0;

  chdr_traffic_source #(.NODE_ID(NODE_ID)) chdr_traffic_source_inst (
    .clk (clk), .rst (rst),
    .i_current_time (cur_time), .i_start_stb (start_stb),
    .i_injection_rate (injection_rate), .i_lines_per_pkt (lines_per_pkt),
    .i_traffic_patt (traffic_patt), .i_num_pkts_to_send (num_pkts),
    .o_m_tdata (m_tdata), .o_m_tlast (m_tlast),
    .o_m_tvalid (m_tvalid), .i_m_tready (m_tready),
    .o_session_active (session_active), .o_session_duration (session_duration),
    .o_xfer_count (xfer_count), .o_pkt_count (pkt_count)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Destination the pattern rules give for packet pkt of a session
  function automatic logic [15:0] expected_dst(input logic [7:0] patt, input int pkt);
    case (patt)
      PATT_LOOPBACK:       return 16'(NODE_ID);
      PATT_NEIGHBOR:       return 16'((NODE_ID + 1) % NUM_NODES);
      PATT_BIT_COMPLEMENT: return 16'(NUM_NODES - 1 - NODE_ID);
      PATT_SEQUENTIAL:     return 16'((NODE_ID + pkt) % NUM_NODES);
      default:             return 16'hffff;
    endcase
  endfunction

  // Header on line 0, ramp from line 2; line 1 is the timestamp
  function automatic logic [63:0] expected_beat(input int pkt, input int line, input int lines,
                                                input logic [15:0] dst);
    if (line == 0)
      return pack_chdr_hdr(1'b1, 12'(pkt), 16'(lines * 8), 16'(NODE_ID), dst);
    return 64'(line - 2);
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_data(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) flag_error($sformatf("Mismatch %s: expected %h, actual %h", what, exp, act));
  endtask

  task automatic check_last(input string what, input logic exp, input logic act);
    if (act !== exp) flag_error($sformatf("Mismatch %s tlast: expected %b, actual %b",
                                          what, exp, act));
  endtask

  task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) flag_error($sformatf("Mismatch %s: expected %0d, actual %0d", what, exp, act));
  endtask

  // Time counter and tready pattern, both driven after the edge
  always @(posedge clk) begin
    #2;
    cur_time <= cur_time + 64'd1;
    if (ready_random) begin
      rng = xorshift32(rng);
      m_tready <= rng[4];
    end else begin
      m_tready <= 1'b1;
    end
  end

  // Monitor, beats seen at negedge transfer on the next rising edge
  always @(negedge clk) begin
    if (!rst && m_tvalid && m_tready) begin
      if (exp_line == 1) begin
        mon_ts = m_tdata;
        if (mon_ts < sess_start || mon_ts < last_ts || mon_ts > cur_time)
          flag_error($sformatf("%s pkt %0d: timestamp %0d outside %0d..%0d",
                               cur_name, exp_pkt, mon_ts, last_ts, cur_time));
        last_ts = mon_ts;
      end else begin
        if (cfg_patt == PATT_UNIFORM || cfg_patt == PATT_UNIFORM_OTHERS) begin
          mon_dst = m_tdata[15:0];  // Random destination, checked by range only
          if (exp_line == 0 && (mon_dst >= 16'(NUM_NODES) ||
              (cfg_patt == PATT_UNIFORM_OTHERS && mon_dst == 16'(NODE_ID))))
            flag_error($sformatf("%s pkt %0d: destination %0d not allowed",
                                 cur_name, exp_pkt, mon_dst));
        end else begin
          mon_dst = expected_dst(cfg_patt, exp_pkt);
        end
        check_data($sformatf("%s pkt %0d line %0d", cur_name, exp_pkt, exp_line),
                   expected_beat(exp_pkt, exp_line, cfg_lines, mon_dst), m_tdata);
      end
      check_last($sformatf("%s pkt %0d line %0d", cur_name, exp_pkt, exp_line),
                 exp_line == cfg_lines - 1, m_tlast);
      beats_seen++;
      if (exp_line == cfg_lines - 1) begin
        exp_line = 0;
        exp_pkt++;
      end else begin
        exp_line++;
      end
    end
  end

  task automatic start_session(input string name, input logic [7:0] patt, input int rate,
                               input int lines, input int npkts);
    @(posedge clk);
    #2;
    cur_name   = name;
    cfg_patt   = patt;
    cfg_lines  = lines;
    cfg_pkts   = npkts;
    cfg_total  = lines * npkts;
    exp_pkt    = 0;
    exp_line   = 0;
    beats_seen = 0;
    last_ts    = '0;
    err_mark   = errors;
    injection_rate = 8'(rate);
    traffic_patt   = patt;
    lines_per_pkt  = 16'(lines);
    num_pkts       = 32'(npkts);
    start_stb      = 1'b1;
    @(negedge clk);
    sess_start = cur_time;  // Value the generator captures at the next edge
    @(posedge clk);
    #2 start_stb = 1'b0;
  endtask

  task automatic finish_session();
    while (beats_seen < cfg_total) @(negedge clk);
    repeat (8) @(negedge clk);  // Room for stray extra beats
    check_count({cur_name, " lines out"}, 32'(cfg_total), 32'(beats_seen));
    if (session_active) flag_error({cur_name, ": session still active after all lines"});
    check_count({cur_name, " pkt_count"}, 32'(cfg_pkts), pkt_count);
    check_count({cur_name, " xfer_count"}, 32'(cfg_total), xfer_count);
    if (session_duration == 64'd0 || session_duration > cur_time - sess_start)
      flag_error($sformatf("%s: session duration %0d not within elapsed %0d",
                           cur_name, session_duration, cur_time - sess_start));
    tests_run++;
    if (errors == err_mark) begin
      tests_passed++;
      $display("%s: ok, %0d lines", cur_name, beats_seen);
    end else begin
      $display("%s: FAILED with %0d errors", cur_name, errors - err_mark);
    end
  endtask

  initial begin
    int lines;
    int npkts;
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;

    start_session("loopback format", PATT_LOOPBACK, 100, 6, 4);
    finish_session();
    start_session("sequential", PATT_SEQUENTIAL, 100, 5, 5);
    finish_session();
    start_session("neighbor", PATT_NEIGHBOR, 100, 5, 5);
    finish_session();
    start_session("complement", PATT_BIT_COMPLEMENT, 100, 5, 5);
    finish_session();
    start_session("uniform", PATT_UNIFORM, 100, 6, 40);
    finish_session();
    start_session("uniform others", PATT_UNIFORM_OTHERS, 100, 6, 40);
    finish_session();

    // Random sizes and a random sink
    @(negedge clk);
    rng = xorshift32(rng);
    lines = 3 + int'(rng % 30);
    rng = xorshift32(rng);
    npkts = 10 + int'(rng % 11);
    ready_random = 1'b1;
    start_session("back-pressure", PATT_SEQUENTIAL, 100, lines, npkts);
    finish_session();
    ready_random = 1'b0;

    // Rate 0 holds everything back, then rate 50 lets the session drain
    start_session("rate and metrics", PATT_NEIGHBOR, 0, 8, 10);
    repeat (200) begin
      @(negedge clk);
      if (!session_active) flag_error("rate and metrics: session ended at rate 0");
    end
    check_count("rate and metrics beats at rate 0", 32'd0, 32'(beats_seen));
    @(posedge clk);
    #2 injection_rate = 8'd50;
    finish_session();

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout in %s after %0d cycles, %0d lines seen", cur_name, WATCHDOG, beats_seen);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/chdr_tg_pkg.sv
verilog/tg_lfsr.sv
verilog/chdr_pkt_gen.sv
verilog/axis_fifo.sv
verilog/ts_insert_throttle.sv
verilog/axis_pkt_gate.sv
verilog/chdr_traffic_source.sv
dv/chdr_traffic_source_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module chdr_traffic_source_tb -f filelist.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  exit 1
fi
exit 0
